//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;   // instruction and data width
    localparam int opc_w = 7;

    // major opcodes the fetch path cares about
    localparam logic [opc_w-1:0] opc_jal = 7'b1101111;
    localparam logic [opc_w-1:0] opc_branch = 7'b1100011;

    // low opcode field of an instruction word
    function automatic logic [opc_w-1:0] opcode(input logic [xlen-1:0] ins);
        return ins[opc_w-1:0];
    endfunction

    // sign-extended J-type immediate, bit 0 always zero
    function automatic logic [xlen-1:0] j_imm(input logic [xlen-1:0] ins);
        return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    endfunction

endpackage

//--- rtl/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // byte address width seen by the fetch path
    localparam int addr_w_default = 32;

    // sizes below must be powers of two
    localparam int mem_words_default = 1024;   // instruction memory depth
    localparam int cache_lines_default = 16;   // one word per line
    localparam int bp_entries_default = 32;    // predictor table entries

endpackage

//--- rtl/inst_mem.sv
module inst_mem #(
    parameter int mem_words = 1024
) (
    input  logic                         clk_in,
    input  logic                         mem_en,
    input  logic                         mem_we,
    input  logic [$clog2(mem_words)-1:0] mem_addr,
    input  logic [31:0]                  mem_wdata,
    output logic [31:0]                  mem_rdata
);

    logic [31:0] mem [mem_words];

    // registered read, new data visible on a write
    always_ff @(posedge clk_in) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
                mem_rdata <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

//--- rtl/mem_arbiter.sv
module mem_arbiter #(
    parameter int mem_words = 1024
) (
    input  logic                         clk_in,
    input  logic                         jalr_reset,
    input  logic                         refill_req,
    input  logic [31:0]                  refill_addr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  paddr,
    input  logic [31:0]                  pwdata,
    input  logic [31:0]                  mem_rdata,
    output logic [31:0]                  refill_data,
    output logic                         refill_ready,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         mem_en,
    output logic                         mem_we,
    output logic [$clog2(mem_words)-1:0] mem_addr,
    output logic [31:0]                  mem_wdata
);

    localparam int idx_w = $clog2(mem_words);

    logic req0;      // cache refill
    logic req1;      // APB host, access phase
    logic busy;
    logic grant1;
    logic start;
    logic last1;     // host granted last and owns the transfer in flight

    assign req0 = refill_req;
    assign req1 = psel && penable;

    // one transfer in flight, from grant to ready
    assign busy = mem_en || refill_ready || pready;
    assign start = !busy && (req0 || req1);

    // round robin only matters when both wait
    assign grant1 = (req0 && req1) ? !last1 : req1;

    // read data comes straight from the memory on the ready cycle
    assign refill_data = mem_rdata;
    assign prdata = mem_rdata;

    always_ff @(posedge clk_in) begin
        if (jalr_reset) begin
            mem_en <= 1'b0;
            mem_we <= 1'b0;
            refill_ready <= 1'b0;
            pready <= 1'b0;
            last1 <= 1'b0;
        end else begin
            refill_ready <= mem_en && !last1;
            pready <= mem_en && last1;
            mem_en <= start;
            mem_we <= start && grant1 && pwrite;   // refills only read
            if (start) begin
                last1 <= grant1;
            end
        end
    end

    // byte address to word index
    always_ff @(posedge clk_in) begin
        if (start) begin
            mem_addr <= grant1 ? paddr[idx_w+1:2] : refill_addr[idx_w+1:2];
            mem_wdata <= pwdata;
        end
    end

endmodule

//--- rtl/branch_predictor.sv
module branch_predictor #(
    parameter int bp_entries = 32
) (
    input  logic        clk_in,
    input  logic        jalr_reset,
    input  logic [31:0] bp_pc,
    input  logic [31:0] bp_ins,
    input  logic        resolve_valid,
    input  logic [31:0] resolve_pc,
    input  logic        resolve_taken,
    input  logic [31:0] resolve_target,
    output logic        predict_jump,
    output logic [31:0] predict_pc
);

    localparam int idx_w = $clog2(bp_entries);
    localparam int tag_w = fetch_cfg_pkg::addr_w_default - idx_w - 2;

    logic [1:0] ctr [bp_entries];
    logic [tag_w-1:0] tag_tab [bp_entries];
    logic [31:0] tgt_tab [bp_entries];

    logic [idx_w-1:0] rd_idx;
    logic [idx_w-1:0] wr_idx;
    logic is_branch;

    assign rd_idx = bp_pc[idx_w+1:2];
    assign wr_idx = resolve_pc[idx_w+1:2];
    assign is_branch = rv_isa_pkg::opcode(bp_ins) == rv_isa_pkg::opc_branch;

    // taken needs a conditional branch, matching tag and counter of 2 or 3
    assign predict_jump = is_branch && ctr[rd_idx][1]
                          && (tag_tab[rd_idx] == bp_pc[idx_w+2 +: tag_w]);
    assign predict_pc = predict_jump ? tgt_tab[rd_idx] : bp_pc + 32'd4;

    always_ff @(posedge clk_in) begin
        if (jalr_reset) begin
            for (int i = 0; i < bp_entries; i++) begin
                ctr[i] <= 2'd1;   // weakly not taken
            end
        end else if (resolve_valid) begin
            if (resolve_taken && ctr[wr_idx] != 2'd3) begin
                ctr[wr_idx] <= ctr[wr_idx] + 2'd1;
            end else if (!resolve_taken && ctr[wr_idx] != 2'd0) begin
                ctr[wr_idx] <= ctr[wr_idx] - 2'd1;
            end
        end
    end

    // target and tag only on a taken outcome
    always_ff @(posedge clk_in) begin
        if (resolve_valid && resolve_taken) begin
            tag_tab[wr_idx] <= resolve_pc[idx_w+2 +: tag_w];
            tgt_tab[wr_idx] <= resolve_target;
        end
    end

endmodule

//--- rtl/icache.sv
module icache #(
    parameter int cache_lines = 16
) (
    input  logic        clk_in,
    input  logic        jalr_reset,
    input  logic [31:0] fetch_pc,
    input  logic        fetch_req,
    input  logic [31:0] refill_data,
    input  logic        refill_ready,
    output logic [31:0] cache_ins,
    output logic        cache_ready,
    output logic        refill_req,
    output logic [31:0] refill_addr
);

    localparam int idx_w = $clog2(cache_lines);
    localparam int tag_w = fetch_cfg_pkg::addr_w_default - idx_w - 2;

    logic [31:0] data_mem [cache_lines];
    logic [tag_w-1:0] tag_mem [cache_lines];
    logic [cache_lines-1:0] valid;

    logic [idx_w-1:0] req_idx;
    logic [tag_w-1:0] req_tag;
    logic [idx_w-1:0] fill_idx;
    logic [tag_w-1:0] fill_tag;
    logic hit;
    logic fill_done;

    assign req_idx = fetch_pc[idx_w+1:2];
    assign req_tag = fetch_pc[idx_w+2 +: tag_w];
    assign fill_idx = refill_addr[idx_w+1:2];   // missed address kept in refill_addr
    assign fill_tag = refill_addr[idx_w+2 +: tag_w];

    assign hit = valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign fill_done = refill_req && refill_ready;

    // control
    always_ff @(posedge clk_in) begin
        if (jalr_reset) begin
            valid <= '0;
            cache_ready <= 1'b0;
            refill_req <= 1'b0;
        end else begin
            cache_ready <= 1'b0;
            if (refill_req) begin
                if (refill_ready) begin
                    refill_req <= 1'b0;
                    valid[fill_idx] <= 1'b1;
                    cache_ready <= 1'b1;
                end
            end else if (fetch_req) begin
                if (hit) begin
                    cache_ready <= 1'b1;
                end else begin
                    refill_req <= 1'b1;   // held until the arbiter answers
                end
            end
        end
    end

    // line data, tags and returned word
    always_ff @(posedge clk_in) begin
        if (fill_done) begin
            data_mem[fill_idx] <= refill_data;
            tag_mem[fill_idx] <= fill_tag;
            cache_ins <= refill_data;   // forward the refilled word
        end else if (fetch_req && !refill_req) begin
            cache_ins <= data_mem[req_idx];
            if (!hit) begin
                refill_addr <= {fetch_pc[31:2], 2'b00};
            end
        end
    end

endmodule

//--- rtl/ifetcher.sv
module ifetcher (
    input  logic        clk_in,
    input  logic        jalr_reset,
    input  logic        rdy_in,
    input  logic        stall,
    input  logic [31:0] cache_ins,
    input  logic        cache_ready,
    input  logic        predict_jump,
    input  logic [31:0] predict_pc,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    output logic [31:0] fetch_pc,
    output logic        fetch_req,
    output logic [31:0] bp_pc,
    output logic [31:0] bp_ins,
    output logic [31:0] out_ins,
    output logic [31:0] out_pc,
    output logic        out_jump,
    output logic        out_valid
);

    typedef enum logic {
        st_idle,
        st_wait
    } state_t;

    state_t state;
    logic [31:0] pc;
    logic [rv_isa_pkg::xlen-1:0] held_ins;   // result parked while stalled
    logic have_ins;
    logic discard;     // stale response still due from the cache
    logic ins_avail;
    logic outstanding;
    logic [rv_isa_pkg::xlen-1:0] cur_ins;

    assign cur_ins = have_ins ? held_ins : cache_ins;
    assign ins_avail = cache_ready || have_ins;

    // request issued but nothing back yet
    assign outstanding = (state == st_wait) && !have_ins && !cache_ready;

    // predictor looks at the instruction being consumed
    assign bp_pc = pc;
    assign bp_ins = cur_ins;

    always_ff @(posedge clk_in) begin
        if (jalr_reset) begin
            pc <= '0;
            state <= st_idle;
            fetch_pc <= '0;
            fetch_req <= 1'b0;
            out_valid <= 1'b0;
            out_jump <= 1'b0;
            have_ins <= 1'b0;
            discard <= 1'b0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
            fetch_req <= 1'b0;
            out_valid <= 1'b0;
            have_ins <= 1'b0;
            // keep waiting only to swallow the old response
            discard <= outstanding;
            state <= outstanding ? st_wait : st_idle;
        end else if (!rdy_in) begin
            fetch_req <= 1'b0;   // pulses must not repeat while paused
            out_valid <= 1'b0;
        end else begin
            fetch_req <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (!stall) begin
                        fetch_pc <= pc;
                        fetch_req <= 1'b1;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (discard) begin
                        if (cache_ready) begin
                            discard <= 1'b0;
                            state <= st_idle;
                        end
                    end else if (ins_avail) begin
                        if (stall) begin
                            if (!have_ins) begin
                                held_ins <= cache_ins;
                                have_ins <= 1'b1;
                            end
                        end else begin
                            // JAL target known here, no need to ask the predictor
                            if (rv_isa_pkg::opcode(cur_ins) == rv_isa_pkg::opc_jal) begin
                                out_jump <= 1'b1;
                                pc <= pc + rv_isa_pkg::j_imm(cur_ins);
                            end else begin
                                out_jump <= predict_jump;
                                pc <= predict_pc;
                            end
                            out_ins <= cur_ins;
                            out_pc <= pc;
                            out_valid <= 1'b1;
                            have_ins <= 1'b0;
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- rtl/fetch_top.sv
module fetch_top #(
    parameter int mem_words = fetch_cfg_pkg::mem_words_default,
    parameter int cache_lines = fetch_cfg_pkg::cache_lines_default,
    parameter int bp_entries = fetch_cfg_pkg::bp_entries_default
) (
    input  logic        clk_in,
    input  logic        jalr_reset,
    input  logic        rdy_in,
    input  logic        stall,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        resolve_valid,
    input  logic [31:0] resolve_pc,
    input  logic        resolve_taken,
    input  logic [31:0] resolve_target,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic [31:0] out_ins,
    output logic [31:0] out_pc,
    output logic        out_jump,
    output logic        out_valid
);

    localparam int mem_idx_w = $clog2(mem_words);

    logic [31:0] fetch_pc, cache_ins, bp_pc, bp_ins, predict_pc;
    logic fetch_req, cache_ready, predict_jump;
    logic [31:0] refill_addr, refill_data;
    logic refill_req, refill_ready;
    logic mem_en, mem_we;
    logic [mem_idx_w-1:0] mem_addr;
    logic [31:0] mem_wdata, mem_rdata;

    ifetcher u_fetch (
        .clk_in, .jalr_reset, .rdy_in, .stall, .cache_ins, .cache_ready,
        .predict_jump, .predict_pc, .redirect_valid, .redirect_pc,
        .fetch_pc, .fetch_req, .bp_pc, .bp_ins,
        .out_ins, .out_pc, .out_jump, .out_valid
    );

    icache #(.cache_lines(cache_lines)) u_cache (
        .clk_in, .jalr_reset, .fetch_pc, .fetch_req, .refill_data, .refill_ready,
        .cache_ins, .cache_ready, .refill_req, .refill_addr
    );

    branch_predictor #(.bp_entries(bp_entries)) u_bp (
        .clk_in, .jalr_reset, .bp_pc, .bp_ins,
        .resolve_valid, .resolve_pc, .resolve_taken, .resolve_target,
        .predict_jump, .predict_pc
    );

    mem_arbiter #(.mem_words(mem_words)) u_arb (
        .clk_in, .jalr_reset, .refill_req, .refill_addr,
        .psel, .penable, .pwrite, .paddr, .pwdata, .mem_rdata,
        .refill_data, .refill_ready, .prdata, .pready,
        .mem_en, .mem_we, .mem_addr, .mem_wdata
    );

    inst_mem #(.mem_words(mem_words)) u_mem (
        .clk_in, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

endmodule

//--- tests/fetch_assertions.sv
module fetch_assertions (
    input logic clk_in,
    input logic jalr_reset,
    input logic redirect_valid,
    input logic fetch_req,
    input logic out_valid
);

    // one request per idle visit
    a_req_pulse: assert property (@(posedge clk_in) fetch_req |=> !fetch_req)
        else $error("fetch_req high in two consecutive cycles");

    a_redirect_flush: assert property (@(posedge clk_in) redirect_valid |=> !out_valid)
        else $error("out_valid high in the cycle after redirect_valid");

    // reset leaves both pulses low
    a_reset_quiet: assert property (@(posedge clk_in) jalr_reset |=> !fetch_req && !out_valid)
        else $error("fetch_req or out_valid high in the cycle after jalr_reset");

endmodule

bind ifetcher fetch_assertions u_assert (
    .clk_in(clk_in),
    .jalr_reset(jalr_reset),
    .redirect_valid(redirect_valid),
    .fetch_req(fetch_req),
    .out_valid(out_valid)
);

//--- tests/fetch_tb.sv
module fetch_tb;

    localparam int expected_beats = 109;   // sum of all beat waits below
    localparam int load_words = 32;        // each written then read back over APB
    localparam int watchdog_cycles = 200 * (expected_beats + 2 * load_words);

    logic clk_in, jalr_reset, rdy_in, stall;
    logic redirect_valid, resolve_valid, resolve_taken;
    logic [31:0] redirect_pc, resolve_pc, resolve_target;
    logic psel, penable, pwrite, pready;
    logic [31:0] paddr, pwdata, prdata;
    logic [31:0] out_ins, out_pc;
    logic out_jump, out_valid;

    logic [31:0] prog [128];                   // words 0x000 to 0x1fc
    logic [31:0] jal_target [logic [31:0]];    // pc of each JAL to its target
    logic [31:0] trained_tgt [logic [31:0]];   // branches the predictor has learned
    logic [15:0] lfsr = 16'd67;
    logic [31:0] exp_pc = '0;
    logic [32:0] nxt;
    logic [31:0] r;
    logic [31:0] rd_word;
    int beats = 0;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_errors = 0;

    fetch_top uut (.*);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // random OP or OP-IMM word, never a control transfer
    function automatic logic [31:0] filler_ins();
        logic [31:0] upper;
        logic [6:0] opc;
        upper = take_bits(25);
        opc = (take_bits(1) == 32'd1) ? 7'b0110011 : 7'b0010011;
        return {upper[24:0], opc};
    endfunction

    task automatic place_jal(input logic [31:0] pc, input logic [31:0] target);
        logic [31:0] off;
        off = target - pc;
        prog[pc[8:2]] = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
        jal_target[pc] = target;
    endtask

    // expected jump flag and next pc after the instruction at pc
    function automatic logic [32:0] ref_next(input logic [31:0] pc);
        if (jal_target.exists(pc))
            return {1'b1, jal_target[pc]};
        if (trained_tgt.exists(pc))
            return {1'b1, trained_tgt[pc]};
        return {1'b0, pc + 32'd4};
    endfunction

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_in);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk_in);
        penable = 1'b1;   // access phase
        @(posedge clk_in);
        while (!pready) @(posedge clk_in);
        @(negedge clk_in);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk_in);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk_in);
        penable = 1'b1;
        @(posedge clk_in);
        while (!pready) @(posedge clk_in);
        data = prdata;   // valid on the ready cycle
        @(negedge clk_in);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_beats(input int n);
        int target;
        target = beats + n;
        while (beats < target) @(negedge clk_in);
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(negedge clk_in);
        redirect_valid = 1'b1;
        redirect_pc = pc;
        @(negedge clk_in);
        redirect_valid = 1'b0;
    endtask

    task automatic train_taken(input logic [31:0] pc, input logic [31:0] target);
        repeat (2) begin
            @(negedge clk_in);
            resolve_valid = 1'b1;
            resolve_pc = pc;
            resolve_taken = 1'b1;
            resolve_target = target;
        end
        @(negedge clk_in);
        resolve_valid = 1'b0;
        trained_tgt[pc] = target;   // counter now 3
    endtask

    task automatic random_stalls(input int n);
        int target;
        target = beats + n;
        while (beats < target) begin
            stall = 1'b1;
            repeat (take_bits(3)) @(negedge clk_in);
            stall = 1'b0;
            repeat (take_bits(3) + 1) @(negedge clk_in);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // compare every decoder beat with the reference walk
    always @(posedge clk_in) begin
        if (out_valid) begin
            nxt = ref_next(exp_pc);
            if (out_pc !== exp_pc) begin
                $display("mismatch out_pc: got %h expected %h", out_pc, exp_pc);
                errors++;
            end
            if (out_ins !== prog[exp_pc[8:2]]) begin
                $display("mismatch out_ins: got %h expected %h", out_ins, prog[exp_pc[8:2]]);
                errors++;
            end
            if (out_jump !== nxt[32]) begin
                $display("mismatch out_jump: got %h expected %h", out_jump, nxt[32]);
                errors++;
            end
            exp_pc = nxt[31:0];
            beats++;
        end
        if (redirect_valid)
            exp_pc = redirect_pc;   // old path is dead from here
    end

    initial begin
        jalr_reset = 1'b1;
        rdy_in = 1'b1;
        stall = 1'b1;   // held while the program loads
        redirect_valid = 1'b0;
        redirect_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < 80; i++)
            prog[i] = filler_ins();
        place_jal(32'h03c, 32'h000);   // loop back, negative offset
        place_jal(32'h100, 32'h110);   // skips three words
        place_jal(32'h120, 32'h100);
        place_jal(32'h134, 32'h100);
        r = take_bits(25);
        prog[68] = {r[24:0], 7'b1100011};   // conditional branch at 0x110
        repeat (4) @(negedge clk_in);
        jalr_reset = 1'b0;
        for (int i = 0; i < 80; i++)
            if (i < 16 || i >= 64)
                apb_write(i * 4, prog[i]);
        for (int i = 0; i < 80; i++) begin
            if (i < 16 || i >= 64) begin
                apb_read(i * 4, rd_word);
                if (rd_word !== prog[i]) begin
                    $display("mismatch prdata: got %h expected %h", rd_word, prog[i]);
                    errors++;
                end
            end
        end
        end_test("apb_load_readback");

        stall = 1'b0;
        wait_beats(1);
        end_test("reset_first_fetch");
        wait_beats(32);
        end_test("straight_line_two_passes");
        redirect_to(32'h100);
        wait_beats(12);
        end_test("jal_forward_backward");
        stall = 1'b1;
        train_taken(32'h110, 32'h130);
        stall = 1'b0;
        wait_beats(14);
        end_test("branch_training");
        redirect_to(32'h008);
        wait_beats(10);
        end_test("redirect_mid_run");
        random_stalls(40);
        end_test("random_stall_gaps");

        $display("%0d tests passed, %0d failed, %0d beats checked, %0d errors",
                 tests_passed, tests_failed, beats, errors);
        if (errors == 0 && tests_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("timeout after %0d cycles with %0d beats seen", watchdog_cycles, beats);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- build.f
rtl/rv_isa_pkg.sv
rtl/fetch_cfg_pkg.sv
rtl/inst_mem.sv
rtl/mem_arbiter.sv
rtl/branch_predictor.sv
rtl/icache.sv
rtl/ifetcher.sv
rtl/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module fetch_tb -o fetch_sim \
    && (./obj_dir/fetch_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log) \
    && cat sim.log \
    && ! grep -q "SOME TESTS FAILED" sim.log
